// ==== compile.f ====
control_pkg.sv
control_cmd_router.sv
control_cmd_watchdog.sv
control_reg_bank.sv
control_subsystem.sv
tb_clock_gen.sv
control_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the control port testbench with Verilator, runs it and
# decides pass or fail from the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module control_subsystem_tb \
    -f compile.f \
    -o sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status."
    exit 1
fi

output=$(./obj_dir/sim)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status."
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// ==== control_subsystem_tb.sv ====
// Testbench for the control port: stimulus, cycle reference model,
// per-cycle comparison, timeout watchdog and summary.
`timescale 1ns/1ps

module control_subsystem_tb;
    localparam int unsigned num_regs = control_pkg::num_regs;
    localparam int unsigned data_bits = num_regs * 8;
    localparam int unsigned sig_bits = control_pkg::signature_bits;
    localparam int unsigned sig_bytes = sig_bits / 8;
    localparam int unsigned ticks = control_pkg::control_ticks;
    localparam int unsigned timer_bits = $clog2(ticks);
    localparam int unsigned total_cmds = 73;
    localparam int unsigned timeout_cycles = total_cmds * 10 + 4 * ticks;
    localparam logic [1:0] mode_idle  = 2'd0;
    localparam logic [1:0] mode_kick  = 2'd1;
    localparam logic [1:0] mode_write = 2'd2;

    logic                 clk;
    logic                 reset;
    logic [7:0]           data_in;
    logic                 data_valid;
    logic                 sys_reset;
    logic                 cmd_error;
    logic [data_bits-1:0] reg_data;

    int          errors;
    int          checks;
    int          reset_pulses; // Pulses seen on the DUT sys_reset.
    string       test_name;
    logic [31:0] rng_state;

    // Reference model state.
    logic [1:0]            m_state;
    logic                  m_kick_done;
    logic                  m_write_done;
    logic                  m_cmd_error;
    logic                  m_sys_reset;
    logic [sig_bits-1:0]   m_cache;
    logic [1:0]            m_count;
    logic [timer_bits-1:0] m_timer;
    logic                  m_phase;
    logic [7:0]            m_addr;
    logic [data_bits-1:0]  m_reg_data;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(2)) clock_gen (.clk(clk), .reset(reset));

    control_subsystem dut (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .data_valid (data_valid),
        .sys_reset  (sys_reset),
        .cmd_error  (cmd_error),
        .reg_data   (reg_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Advances the model by one rising edge with the inputs seen at that edge.
    function void model_step(input logic rst, input logic [7:0] din, input logic dv);
        logic                  kick_en;
        logic                  write_en;
        logic                  next_kick_done;
        logic                  next_write_done;
        logic                  next_error;
        logic [sig_bits-1:0]   shifted;
        logic [timer_bits-1:0] old_timer;
        if (rst) begin
            m_state = mode_idle;
            m_kick_done = 1'b0;
            m_write_done = 1'b0;
            m_cmd_error = 1'b0;
            m_sys_reset = 1'b0;
            m_cache = '0;
            m_count = 2'd0;
            m_timer = timer_bits'(ticks);
            m_phase = 1'b0;
            m_reg_data = '0;
        end else begin
            old_timer = m_timer;
            kick_en = (m_state == mode_kick) && dv && !m_kick_done;
            write_en = (m_state == mode_write) && dv && !m_write_done;
            next_kick_done = kick_en && (m_count == 2'd3);
            next_write_done = write_en && m_phase;
            next_error = (m_state == mode_idle) && dv && din != control_pkg::opcode_kick
                         && din != control_pkg::opcode_write;
            shifted = {m_cache[sig_bits-9:0], din};

            if (m_state == mode_idle && dv && din == control_pkg::opcode_kick) begin
                m_state = mode_kick;
            end else if (m_state == mode_idle && dv && din == control_pkg::opcode_write) begin
                m_state = mode_write;
            end else if ((m_state == mode_kick && m_kick_done)
                         || (m_state == mode_write && m_write_done)) begin
                m_state = mode_idle;
            end

            if (next_kick_done && shifted == control_pkg::signature_pattern) begin
                m_timer = timer_bits'(ticks);
            end else begin
                m_timer = m_timer - 1'b1;
            end
            if (kick_en) begin
                m_cache = next_kick_done ? '0 : shifted;
                m_count = m_count + 1'b1; // Rolls from 3 back to 0.
            end

            if (m_sys_reset) begin
                m_phase = 1'b0;
                m_reg_data = '0;
            end else if (write_en && !m_phase) begin
                m_addr = din;
                m_phase = 1'b1;
            end else if (write_en) begin
                m_phase = 1'b0;
                if (32'(m_addr) < num_regs) m_reg_data[32'(m_addr) * 8 +: 8] = din;
            end

            m_sys_reset = (old_timer == '0); // A zero count shows one edge later.
            m_kick_done = next_kick_done;
            m_write_done = next_write_done;
            m_cmd_error = next_error;
        end
    endfunction

    always @(posedge clk) begin
        model_step(reset, data_in, data_valid);
    end

    task automatic check_value(input string what, input logic [data_bits-1:0] expected,
                               input logic [data_bits-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED [%s] %s expected %h actual %h", test_name, what,
                     expected, actual);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_value("sys_reset", data_bits'(m_sys_reset), data_bits'(sys_reset));
            check_value("cmd_error", data_bits'(m_cmd_error), data_bits'(cmd_error));
            check_value("reg_data", m_reg_data, reg_data);
            if (sys_reset === 1'b1) reset_pulses++;
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic random_gap();
        idle_cycles(1 + int'(next_random() % 4));
    endtask

    task automatic send_byte(input logic [7:0] value);
        data_in = value;
        data_valid = 1'b1;
        @(posedge clk);
        #10 data_valid = 1'b0;
    endtask

    task automatic send_kick(input logic [sig_bits-1:0] sig);
        send_byte(control_pkg::opcode_kick);
        for (int i = 0; i < sig_bytes; i++) send_byte(sig[(sig_bytes - 1 - i) * 8 +: 8]);
        random_gap();
    endtask

    task automatic send_write(input logic [7:0] addr, input logic [7:0] value);
        send_byte(control_pkg::opcode_write);
        send_byte(addr);
        send_byte(value);
        random_gap();
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles.", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0]          r;
        logic [data_bits-1:0] snap;
        int                   pulses_before;
        logic                 found;
        data_in = 8'h00;
        data_valid = 1'b0;
        errors = 0;
        checks = 0;
        reset_pulses = 0;
        rng_state = 32'h5eff_c779;
        test_name = "reset";
        wait (reset === 1'b0);
        send_kick(control_pkg::signature_pattern);

        test_name = "register writes";
        for (int i = 0; i < 20; i++) begin
            r = next_random();
            send_write(8'(r % num_regs), r[15:8]);
        end
        test_name = "invalid writes";
        for (int i = 0; i < 4; i++) begin
            snap = m_reg_data;
            send_write(i < 2 ? 8'(num_regs + i) : 8'(8'h80 + (i - 2) * 8'h7f), 8'hee);
            check_value("unchanged registers", snap, reg_data);
        end

        test_name = "unknown opcode";
        send_byte(8'ha5);
        @(negedge clk);
        check_value("error pulse", data_bits'(1), data_bits'(cmd_error));
        @(posedge clk);
        #10;
        send_write(8'd1, 8'h5a);
        check_value("write after error", data_bits'(8'h5a), data_bits'(reg_data[15:8]));
        send_byte(8'hff);
        random_gap();

        test_name = "correct kicks";
        pulses_before = reset_pulses;
        repeat (9) begin
            send_byte(control_pkg::opcode_kick);
            for (int i = 0; i < sig_bytes; i++) begin
                send_byte(control_pkg::signature_pattern[(sig_bytes - 1 - i) * 8 +: 8]);
            end
            idle_cycles(ticks / 3 - 5);
        end
        check_value("pulses in kick window", '0, data_bits'(reset_pulses - pulses_before));

        test_name = "wrong signature";
        send_kick(control_pkg::signature_pattern);
        for (int i = 0; i < num_regs; i++) send_write(8'(i), 8'(8'h11 * (i + 1)));
        send_kick(control_pkg::signature_pattern ^ 32'h0000_ff00);
        found = 1'b0;
        for (int i = 0; i < ticks + 20 && !found; i++) begin
            @(negedge clk);
            if (sys_reset === 1'b1) found = 1'b1;
        end
        checks++;
        assert (found) else begin
            errors++;
            $display("No sys_reset pulse came after the kick with a wrong signature.");
        end
        if (found) begin
            @(negedge clk);
            check_value("registers after expiry", '0, reg_data);
        end
        @(posedge clk);
        #10;

        test_name = "interleaved";
        for (int i = 0; i < 30; i++) begin
            r = next_random();
            if (r[0] && r[3:1] == 3'd0) begin
                send_kick(control_pkg::signature_pattern ^ (32'hff << (8 * r[5:4])));
            end else if (r[0]) begin
                send_kick(control_pkg::signature_pattern);
            end else begin
                send_write(8'(r[15:8] % 6), r[23:16]);
            end
        end
        idle_cycles(2);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end
endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and power-on reset generator.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int unsigned PERIOD       = 100,
    parameter int unsigned RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset drops a little after a rising edge, like the other inputs.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 reset = 1'b0;
    end
endmodule

// ==== control_subsystem.sv ====
// Top level of the control port: router, watchdog and register bank.
`timescale 1ns/1ps

module control_subsystem (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [7:0]                        data_in,
    input  logic                              data_valid,
    output logic                              sys_reset,
    output logic                              cmd_error,
    output logic [control_pkg::num_regs*8-1:0] reg_data
);
    logic kick_enable;
    logic kick_done;
    logic write_enable;
    logic write_done;

    control_cmd_router u_router (
        .clk          (clk),
        .reset        (reset),
        .data_in      (data_in),
        .data_valid   (data_valid),
        .kick_done    (kick_done),
        .write_done   (write_done),
        .kick_enable  (kick_enable),
        .write_enable (write_enable),
        .cmd_error    (cmd_error)
    );

    control_cmd_watchdog #(
        .SIGNATURE_BITS    (control_pkg::signature_bits),
        .SIGNATURE_PATTERN (control_pkg::signature_pattern),
        .CONTROL_TICKS     (control_pkg::control_ticks)
    ) u_watchdog (
        .clk       (clk),
        .reset     (reset),
        .data_in   (data_in),
        .enable    (kick_enable),
        .sys_reset (sys_reset),
        .done      (kick_done)
    );

    // Watchdog expiry also clears the register bank.
    control_reg_bank #(
        .NUM_REGS (control_pkg::num_regs)
    ) u_reg_bank (
        .clk       (clk),
        .reset     (reset),
        .sys_reset (sys_reset),
        .data_in   (data_in),
        .enable    (write_enable),
        .reg_data  (reg_data),
        .done      (write_done)
    );

endmodule

// ==== control_reg_bank.sv ====
// Register write handler: address and value byte collection
// and the bank of control registers.
`timescale 1ns/1ps

module control_reg_bank #(
    parameter int unsigned NUM_REGS = control_pkg::num_regs
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sys_reset,
    input  logic [7:0]            data_in,
    input  logic                  enable,
    output logic [NUM_REGS*8-1:0] reg_data,
    output logic                  done
);
    logic       value_phase; // Low while waiting for the address byte.
    logic [7:0] addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            value_phase <= 1'b0;
            reg_data    <= '0;
            done        <= 1'b0;
        end else begin
            done <= enable && value_phase;

            if (sys_reset) begin
                // A watchdog expiry wipes the bank and any half-received write.
                value_phase <= 1'b0;
                reg_data    <= '0;
            end else if (enable) begin
                if (!value_phase) begin
                    value_phase <= 1'b1;
                end else begin
                    value_phase <= 1'b0;
                    // Addresses of NUM_REGS and above match no register.
                    for (int i = 0; i < NUM_REGS; i++) begin
                        if (addr == 8'(i)) begin
                            reg_data[i*8 +: 8] <= data_in;
                        end
                    end
                end
            end
        end
    end

    // Latches the address byte of a write.
    always_ff @(posedge clk) begin
        if (enable && !value_phase) begin
            addr <= data_in;
        end
    end

    // The router holds back payload bytes while done is high.
    a_no_byte_on_done : assert property (
        @(posedge clk) disable iff (reset) done |-> !enable
    );

endmodule

// ==== control_cmd_watchdog.sv ====
// Watchdog handler: signature byte capture, countdown timer
// and the one-cycle system reset on expiry.
`timescale 1ns/1ps

module control_cmd_watchdog #(
    parameter int unsigned SIGNATURE_BITS = control_pkg::signature_bits,
    parameter logic [SIGNATURE_BITS-1:0] SIGNATURE_PATTERN = control_pkg::signature_pattern,
    parameter int unsigned CONTROL_TICKS = control_pkg::control_ticks
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       enable,
    output logic       sys_reset,
    output logic       done
);
    localparam int unsigned sig_bytes = SIGNATURE_BITS / 8;
    localparam int unsigned count_bits = $clog2(sig_bytes);
    localparam int unsigned timer_bits = $clog2(CONTROL_TICKS);

    logic [SIGNATURE_BITS-1:0] cache;
    logic [SIGNATURE_BITS-1:0] next_cache;
    logic [count_bits-1:0]     byte_count;
    logic [timer_bits-1:0]     timer;
    logic                      last_byte;

    // Cache contents once the current byte is shifted in.
    assign next_cache = {cache[SIGNATURE_BITS-9:0], data_in};
    assign last_byte  = (byte_count == count_bits'(sig_bytes - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            cache      <= '0;
            byte_count <= '0;
            timer      <= timer_bits'(CONTROL_TICKS);
            sys_reset  <= 1'b0;
            done       <= 1'b0;
        end else begin
            sys_reset <= (timer == '0); // The expiry pulse lags the zero count by one cycle.
            done      <= enable && last_byte;

            if (enable && next_cache == SIGNATURE_PATTERN) begin
                timer <= timer_bits'(CONTROL_TICKS);
            end else begin
                timer <= timer - 1'b1; // Wraps below zero.
            end

            if (enable) begin
                if (last_byte) begin
                    cache      <= '0;
                    byte_count <= '0;
                end else begin
                    cache      <= next_cache;
                    byte_count <= byte_count + 1'b1;
                end
            end
        end
    end

    // The router holds back payload bytes while done is high.
    a_no_byte_on_done : assert property (
        @(posedge clk) disable iff (reset) done |-> !enable
    );

endmodule

// ==== control_cmd_router.sv ====
// Command router: opcode decode and steering of payload byte strobes
// to the watchdog or the register bank.
`timescale 1ns/1ps

module control_cmd_router (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       data_valid,
    input  logic       kick_done,
    input  logic       write_done,
    output logic       kick_enable,
    output logic       write_enable,
    output logic       cmd_error
);
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_kick  = 2'd1;
    localparam logic [1:0] st_write = 2'd2;

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;
            case (state)
                st_idle: begin
                    // The first strobed byte of a command is its opcode.
                    if (data_valid) begin
                        if (data_in == control_pkg::opcode_kick) begin
                            state <= st_kick;
                        end else if (data_in == control_pkg::opcode_write) begin
                            state <= st_write;
                        end else begin
                            cmd_error <= 1'b1; // An unknown opcode is dropped.
                        end
                    end
                end
                st_kick: begin
                    if (kick_done) begin
                        state <= st_idle;
                    end
                end
                st_write: begin
                    if (write_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Payload strobes pass straight through to the busy handler.
    // A byte that lands on the done cycle is dropped.
    assign kick_enable  = (state == st_kick) && data_valid && !kick_done;
    assign write_enable = (state == st_write) && data_valid && !write_done;

    // A done pulse must come from the handler that is currently selected.
    a_done_matches_state : assert property (
        @(posedge clk) disable iff (reset)
        (kick_done |-> state == st_kick) and (write_done |-> state == st_write)
    );

endmodule

// ==== control_pkg.sv ====
// Shared constants for the byte-serial control port.
// Signature, watchdog timing, opcodes and register bank size.

package control_pkg;

    // Watchdog signature, sent as four payload bytes, most significant first.
    localparam int unsigned signature_bits = 32;
    localparam logic [signature_bits-1:0] signature_pattern = 32'hc0de_f00d;

    // Countdown length in cycles.
    // Keep this off a power of two, the counter is sized with its clog2.
    localparam int unsigned control_ticks = 300;

    // Opcode bytes that open a command.
    localparam logic [7:0] opcode_kick  = 8'h57;
    localparam logic [7:0] opcode_write = 8'h52;

    localparam int unsigned num_regs = 4; // Number of 8-bit control registers.

endpackage
